// ==== include/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path and instruction word width
`define XLEN 32

// integer register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// instruction memory, in 32-bit words
`define IMEM_DEPTH 32
`define IMEM_ADDR_W 5

// byte distance between consecutive instructions
`define PC_STEP 4

`endif

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    // funct3 codes, shared by register and immediate forms
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7 values
    localparam logic [6:0] F7_BASE = 7'b0000000;
    // selects SUB over ADD and SRA over SRL
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SRA = 4'd7,
        ALU_SLT = 4'd8
    } alu_op_e;

endpackage

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package core_pkg;

    // one instruction memory write
    typedef struct packed {
        logic [`IMEM_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]        data;
    } imem_load_t;

    // decoder output consumed by the datapath
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
        logic                   imm_sel;
        logic                   we;
        isa_pkg::alu_op_e       op;
    } decoded_t;

    // result of one executed instruction
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       instr;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       wdata;
        logic                   we;
    } retire_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`default_nettype none

`include "cpu_params.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 step,
    input  logic                 imem_wr,
    input  core_pkg::imem_load_t imem_load,
    output logic [`XLEN-1:0]     pc,
    output logic [`XLEN-1:0]     instr
);

    logic [`XLEN-1:0] imem [0:`IMEM_DEPTH-1];
    logic [`IMEM_ADDR_W-1:0] word_addr;

    // loading works in and out of reset, memory is never cleared
    always_ff @(posedge clk) begin
        if (imem_wr) begin
            imem[imem_load.addr] <= imem_load.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (step) begin
            pc <= pc + `PC_STEP;
        end
    end

    // byte offset dropped, upper bits ignored so pc wraps through memory
    assign word_addr = pc[`IMEM_ADDR_W+1:2];
    assign instr     = imem[word_addr];

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`default_nettype none

`include "cpu_params.svh"

module instr_decoder (
    input  logic [`XLEN-1:0]   instr,
    output core_pkg::decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       supported;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_shamt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i     = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    // shift immediates carry only a 5-bit amount
    assign imm_shamt = {{(`XLEN-5){1'b0}}, instr[24:20]};

    always_comb begin
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.rd      = instr[11:7];
        dec.imm     = imm_i;
        dec.imm_sel = 1'b0;
        dec.op      = isa_pkg::ALU_ADD;
        supported   = 1'b0;

        case (opcode)
            isa_pkg::OPC_OP: begin
                supported = 1'b1;
                if (funct7 == isa_pkg::F7_BASE) begin
                    case (funct3)
                        isa_pkg::F3_ADD: dec.op = isa_pkg::ALU_ADD;
                        isa_pkg::F3_SLL: dec.op = isa_pkg::ALU_SLL;
                        isa_pkg::F3_SLT: dec.op = isa_pkg::ALU_SLT;
                        isa_pkg::F3_XOR: dec.op = isa_pkg::ALU_XOR;
                        isa_pkg::F3_SRL: dec.op = isa_pkg::ALU_SRL;
                        isa_pkg::F3_OR:  dec.op = isa_pkg::ALU_OR;
                        isa_pkg::F3_AND: dec.op = isa_pkg::ALU_AND;
                        // SLTU
                        default:         supported = 1'b0;
                    endcase
                end else if (funct7 == isa_pkg::F7_ALT && funct3 == isa_pkg::F3_ADD) begin
                    dec.op = isa_pkg::ALU_SUB;
                end else if (funct7 == isa_pkg::F7_ALT && funct3 == isa_pkg::F3_SRL) begin
                    dec.op = isa_pkg::ALU_SRA;
                end else begin
                    supported = 1'b0;
                end
            end
            isa_pkg::OPC_OP_IMM: begin
                dec.imm_sel = 1'b1;
                supported   = 1'b1;
                case (funct3)
                    isa_pkg::F3_ADD: dec.op = isa_pkg::ALU_ADD;
                    isa_pkg::F3_XOR: dec.op = isa_pkg::ALU_XOR;
                    isa_pkg::F3_OR:  dec.op = isa_pkg::ALU_OR;
                    isa_pkg::F3_SLL: begin
                        dec.imm   = imm_shamt;
                        dec.op    = isa_pkg::ALU_SLL;
                        supported = (funct7 == isa_pkg::F7_BASE);
                    end
                    isa_pkg::F3_SRL: begin
                        dec.imm   = imm_shamt;
                        dec.op    = (funct7 == isa_pkg::F7_ALT) ? isa_pkg::ALU_SRA
                                                                : isa_pkg::ALU_SRL;
                        supported = (funct7 == isa_pkg::F7_BASE) ||
                                    (funct7 == isa_pkg::F7_ALT);
                    end
                    // SLTI, SLTIU and ANDI retire as no-ops
                    default: supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase

        dec.we = supported && (dec.rd != '0);
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

`include "cpu_params.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic                   we,
    input  logic [`XLEN-1:0]       wdata,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // same-cycle write is seen on the next read only
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

`include "cpu_params.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  isa_pkg::alu_op_e op,
    output logic [`XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            isa_pkg::ALU_ADD: result = a + b;
            isa_pkg::ALU_SUB: result = a - b;
            isa_pkg::ALU_AND: result = a & b;
            isa_pkg::ALU_OR:  result = a | b;
            isa_pkg::ALU_XOR: result = a ^ b;
            isa_pkg::ALU_SLL: result = a << shamt;
            isa_pkg::ALU_SRL: result = a >> shamt;
            isa_pkg::ALU_SRA: result = $signed(a) >>> shamt;
            // signed compare, 1 or 0
            isa_pkg::ALU_SLT: result = ($signed(a) < $signed(b)) ? `XLEN'(1) : '0;
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`default_nettype none

`include "cpu_params.svh"

module cpu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 imem_wr,
    input  core_pkg::imem_load_t imem_load,
    input  logic                 run,
    output logic                 retired,
    output core_pkg::retire_t    retire_rec
);

    logic               step;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   instr;
    core_pkg::decoded_t dec;
    logic [`XLEN-1:0]   rdata1;
    logic [`XLEN-1:0]   rdata2;
    logic [`XLEN-1:0]   alu_b;
    logic [`XLEN-1:0]   alu_result;

    // one instruction per edge while running and out of reset
    assign step  = rst_n & run;
    assign alu_b = dec.imm_sel ? dec.imm : rdata2;

    fetch_unit fetch_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .imem_wr   (imem_wr),
        .imem_load (imem_load),
        .pc        (pc),
        .instr     (instr)
    );

    instr_decoder instr_decoder_inst (
        .instr (instr),
        .dec   (dec)
    );

    reg_file reg_file_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rd     (dec.rd),
        .we     (dec.we & step),
        .wdata  (alu_result),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu alu_inst (
        .a      (rdata1),
        .b      (alu_b),
        .op     (dec.op),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired <= 1'b0;
        end else begin
            retired <= step;
        end
    end

    // record only, valid while retired is high
    always_ff @(posedge clk) begin
        if (step) begin
            retire_rec.pc    <= pc;
            retire_rec.instr <= instr;
            retire_rec.rd    <= dec.rd;
            retire_rec.wdata <= alu_result;
            retire_rec.we    <= dec.we;
        end
    end

endmodule

`default_nettype wire

// ==== tb/cpu_sva.sv ====
`default_nettype none

`include "cpu_params.svh"

module cpu_sva (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire logic              retired,
    input wire core_pkg::retire_t retire_rec
);

    // count of failed assertions
    int unsigned fail_count = 0;

    // reset edge clears the retire pulse
    no_retire_in_reset: assert property (
        @(posedge clk) !rst_n |=> !retired
    ) else begin
        fail_count++;
        $error("retire pulse seen during reset");
    end

    // back-to-back retires step pc by one word
    pc_steps: assert property (
        @(posedge clk) disable iff (!rst_n)
        retired && $past(retired) |->
            retire_rec.pc == $past(retire_rec.pc) + `PC_STEP
    ) else begin
        fail_count++;
        $error("pc did not advance by one step between retires");
    end

    no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        retired |-> !(retire_rec.we && retire_rec.rd == '0)
    ) else begin
        fail_count++;
        $error("write enable set with rd equal to x0");
    end

endmodule

bind cpu_top cpu_sva cpu_sva_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .retired    (retired),
    .retire_rec (retire_rec)
);

`default_nettype wire

// ==== tb/cpu_tb.sv ====
`default_nettype none

`include "cpu_params.svh"

module cpu_tb;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS = 4;
    // every test loads the whole memory
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (`IMEM_DEPTH * 20 + RESET_CYCLES);

    logic                 clk;
    logic                 rst_n;
    logic                 imem_wr;
    core_pkg::imem_load_t imem_load;
    logic                 run;
    logic                 retired;
    core_pkg::retire_t    retire_rec;

    logic [`XLEN-1:0] tb_mem [0:`IMEM_DEPTH-1];
    logic [`XLEN-1:0] model_regs [0:`REG_COUNT-1];
    logic [`XLEN-1:0] exp_pc;
    logic [`XLEN-1:0] prog [$];
    logic             stepped;
    int               errors = 0;
    int               retire_count = 0;
    int               target = 0;

    cpu_top cpu_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_wr    (imem_wr),
        .imem_load  (imem_load),
        .run        (run),
        .retired    (retired),
        .retire_rec (retire_rec)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // andi no-op that still varies with every address bit
    function automatic logic [31:0] fill_word(input logic [4:0] addr);
        return enc_i({7'b0, addr}, ~addr, 3'b111, addr);
    endfunction

    function automatic logic [31:0] rand_instr();
        int unsigned sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [4:0]  sh;
        sel = $urandom % 15;
        rd  = 5'($urandom);
        // sources mostly from the registers set up front
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        imm = 12'($urandom);
        sh  = 5'($urandom);
        case (sel)
            0:  return enc_r(7'h00, rs2, rs1, 3'b000, rd);
            1:  return enc_r(7'h20, rs2, rs1, 3'b000, rd);
            2:  return enc_r(7'h00, rs2, rs1, 3'b111, rd);
            3:  return enc_r(7'h00, rs2, rs1, 3'b110, rd);
            4:  return enc_r(7'h00, rs2, rs1, 3'b100, rd);
            5:  return enc_r(7'h00, rs2, rs1, 3'b010, rd);
            6:  return enc_r(7'h00, rs2, rs1, 3'b001, rd);
            7:  return enc_r(7'h00, rs2, rs1, 3'b101, rd);
            8:  return enc_r(7'h20, rs2, rs1, 3'b101, rd);
            9:  return enc_i(imm, rs1, 3'b000, rd);
            10: return enc_i(imm, rs1, 3'b100, rd);
            11: return enc_i(imm, rs1, 3'b110, rd);
            12: return enc_i({7'h00, sh}, rs1, 3'b001, rd);
            13: return enc_i({7'h00, sh}, rs1, 3'b101, rd);
            default: return enc_i({7'h20, sh}, rs1, 3'b101, rd);
        endcase
    endfunction

    // reference model returning {write enable, write data}
    function automatic logic [32:0] ref_exec(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [4:0]  sh;
        logic [31:0] r;
        logic        ok;
        a   = model_regs[ins[19:15]];
        b   = model_regs[ins[24:20]];
        imm = {{20{ins[31]}}, ins[31:20]};
        sh  = ins[24:20];
        r   = '0;
        ok  = 1'b1;
        if (ins[6:0] == 7'b0110011) begin
            case ({ins[31:25], ins[14:12]})
                10'b0000000_000: r = a + b;
                10'b0100000_000: r = a - b;
                10'b0000000_111: r = a & b;
                10'b0000000_110: r = a | b;
                10'b0000000_100: r = a ^ b;
                10'b0000000_010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                10'b0000000_001: r = a << b[4:0];
                10'b0000000_101: r = a >> b[4:0];
                10'b0100000_101: r = $signed(a) >>> b[4:0];
                default:         ok = 1'b0;
            endcase
        end else if (ins[6:0] == 7'b0010011) begin
            case ({ins[31:25], ins[14:12]}) inside
                10'b???????_000: r = a + imm;
                10'b???????_100: r = a ^ imm;
                10'b???????_110: r = a | imm;
                10'b0000000_001: r = a << sh;
                10'b0000000_101: r = a >> sh;
                10'b0100000_101: r = $signed(a) >>> sh;
                default:         ok = 1'b0;
            endcase
        end else begin
            ok = 1'b0;
        end
        return {ok && (ins[11:7] != 5'd0), r};
    endfunction

    task automatic note_failure(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic check_retire();
        logic [31:0] exp_instr;
        logic [32:0] res;
        exp_instr = tb_mem[exp_pc[`IMEM_ADDR_W+1:2]];
        res = ref_exec(exp_instr);
        assert (retire_rec.pc == exp_pc)
            else note_failure($sformatf("pc %h, expected %h", retire_rec.pc, exp_pc));
        assert (retire_rec.instr == exp_instr)
            else note_failure($sformatf("instr %h, expected %h", retire_rec.instr, exp_instr));
        assert (retire_rec.rd == exp_instr[11:7])
            else note_failure($sformatf("rd %0d, expected %0d", retire_rec.rd, exp_instr[11:7]));
        assert (retire_rec.we == res[32])
            else note_failure($sformatf("we %b, expected %b at pc %h", retire_rec.we, res[32],
                                        exp_pc));
        if (res[32]) begin
            assert (retire_rec.wdata == res[31:0])
                else note_failure($sformatf("wdata %h, expected %h for instr %h",
                                            retire_rec.wdata, res[31:0], exp_instr));
            model_regs[exp_instr[11:7]] = res[31:0];
        end
        exp_pc = exp_pc + 32'(`PC_STEP);
        retire_count++;
    endtask

    // retire monitor checks the record one edge after execution
    always begin
        @(posedge clk);
        stepped = rst_n && run;
        #2;
        assert (retired === stepped)
            else note_failure($sformatf("retired %b, expected %b", retired, stepped));
        if (stepped) begin
            check_retire();
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_program();
        logic [31:0] word;
        rst_n = 1'b0;
        run   = 1'b0;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            word = (i < prog.size()) ? prog[i] : fill_word(5'(i));
            tb_mem[i]      = word;
            imem_wr        = 1'b1;
            imem_load.addr = 5'(i);
            imem_load.data = word;
            next_cycle();
        end
        imem_wr = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        for (int k = 0; k < `REG_COUNT; k++) begin
            model_regs[k] = '0;
        end
        exp_pc = '0;
        rst_n  = 1'b1;
    endtask

    task automatic execute(input int n);
        run = 1'b1;
        repeat (n) next_cycle();
        run = 1'b0;
        target += n;
        while (retire_count < target) begin
            next_cycle();
        end
    endtask

    task automatic test_r_type();
        prog.delete();
        prog.push_back(enc_i(12'd100, 5'd0, 3'b000, 5'd1));
        prog.push_back(enc_i(12'hff9, 5'd0, 3'b000, 5'd2));
        prog.push_back(enc_i(12'd3, 5'd0, 3'b000, 5'd3));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
        prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd6));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd7));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd8));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd9));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd10));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'b001, 5'd11));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'b101, 5'd12));
        prog.push_back(enc_r(7'h20, 5'd3, 5'd2, 3'b101, 5'd13));
        load_program();
        // idle with run low before the first retire
        repeat (3) next_cycle();
        execute(prog.size());
    endtask

    task automatic test_i_type();
        prog.delete();
        prog.push_back(enc_i(12'hed4, 5'd0, 3'b000, 5'd1));
        prog.push_back(enc_i(12'hfff, 5'd1, 3'b000, 5'd2));
        prog.push_back(enc_i(12'h5a5, 5'd1, 3'b100, 5'd3));
        prog.push_back(enc_i(12'h0f0, 5'd1, 3'b110, 5'd4));
        prog.push_back(enc_i({7'h00, 5'd4}, 5'd1, 3'b001, 5'd5));
        prog.push_back(enc_i({7'h00, 5'd3}, 5'd1, 3'b101, 5'd6));
        prog.push_back(enc_i({7'h20, 5'd3}, 5'd1, 3'b101, 5'd7));
        prog.push_back(enc_i({7'h20, 5'd31}, 5'd1, 3'b101, 5'd8));
        prog.push_back(enc_i(12'h7ff, 5'd2, 3'b000, 5'd9));
        prog.push_back(enc_i(12'hfff, 5'd1, 3'b100, 5'd10));
        prog.push_back(enc_r(7'h00, 5'd10, 5'd9, 3'b000, 5'd11));
        load_program();
        execute(4);
        // pause mid-program while pc and registers hold
        repeat (3) next_cycle();
        execute(prog.size() - 4);
    endtask

    task automatic test_x0_and_noops();
        prog.delete();
        prog.push_back(enc_i(12'd42, 5'd0, 3'b000, 5'd1));
        prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd0));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        prog.push_back(enc_i(12'd7, 5'd1, 3'b111, 5'd2));
        prog.push_back(enc_i(12'd50, 5'd1, 3'b010, 5'd3));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd4));
        prog.push_back(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd5));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd6));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd0, 3'b011, 5'd7));
        load_program();
        execute(prog.size());
    endtask

    task automatic test_random();
        prog.delete();
        for (int k = 1; k <= 6; k++) begin
            prog.push_back(enc_i(12'($urandom), 5'd0, 3'b000, 5'(k)));
        end
        while (prog.size() < `IMEM_DEPTH) begin
            prog.push_back(rand_instr());
        end
        load_program();
        // two passes so pc wraps through the memory
        execute(2 * `IMEM_DEPTH);
    endtask

    initial begin
        void'($urandom(32'h6a65));
        rst_n     = 1'b0;
        run       = 1'b0;
        imem_wr   = 1'b0;
        imem_load = '0;
        exp_pc    = '0;
        test_r_type();
        test_i_type();
        test_x0_and_noops();
        test_random();
        repeat (2) next_cycle();
        $display("%0d retires checked, %0d check errors, %0d assertion errors",
                 retire_count, errors, cpu_top_inst.cpu_sva_inst.fail_count);
        if (errors == 0 && cpu_top_inst.cpu_sva_inst.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/cpu_top.sv
tb/cpu_sva.sv
tb/cpu_tb.sv

// ==== Makefile ====
TOP := cpu_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

obj_dir/V$(TOP): project.f $(wildcard hdl/*.sv tb/*.sv include/*.svh)
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --assert -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
